/* verilog/host_pkg.sv */
package host_pkg;

    // Command opcodes, codes not listed are acknowledged and ignored
    typedef enum logic [2:0] {
        OP_CLEAR = 3'd0,
        OP_FILL  = 3'd1
    } host_op_e;

    // Character view, kind bit set
    typedef struct packed {
        logic       kind;
        logic       row;
        logic [3:0] col;
        logic [1:0] rsvd;
        logic [7:0] ch;
    } host_char_t;

    // Command view, kind bit clear
    typedef struct packed {
        logic       kind;
        host_op_e   op;
        logic [3:0] rsvd;
        logic [7:0] arg;
    } host_cmd_t;

    typedef union packed {
        host_char_t chr;
        host_cmd_t  cmd;
    } host_word_u;

endpackage

/* verilog/lcd_pkg.sv */
package lcd_pkg;

    typedef logic [7:0] lcd_byte_t;

    // Panel geometry
    localparam int lcd_row_cols = 16;
    localparam int lcd_cells    = 32;

    // HD44780 instruction bytes
    localparam lcd_byte_t lcd_cmd_function_set = 8'h38; // 8-bit bus, 2 lines, 5x8 font
    localparam lcd_byte_t lcd_cmd_display_off  = 8'h08;
    localparam lcd_byte_t lcd_cmd_clear        = 8'h01;
    localparam lcd_byte_t lcd_cmd_entry_mode   = 8'h06; // Increment, no shift
    localparam lcd_byte_t lcd_cmd_display_on   = 8'h0C; // Cursor and blink off

    // Set DDRAM address to the start of a line
    localparam lcd_byte_t lcd_cmd_row0_addr    = 8'h80;
    localparam lcd_byte_t lcd_cmd_row1_addr    = 8'hC0;

    localparam lcd_byte_t lcd_blank = 8'h20; // Space

    // Update periods to wait after reset before the first command
    localparam int power_up_periods = 10;

endpackage

/* verilog/host_decode.sv */
`timescale 1ns/1ps

module host_decode (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 host_req,
    input  host_pkg::host_word_u host_word,
    output logic                 host_ack,
    output logic                 wr_en,
    output logic [4:0]           wr_addr,
    output lcd_pkg::lcd_byte_t   wr_char,
    output logic                 sweep_start,
    output lcd_pkg::lcd_byte_t   sweep_char,
    input  logic                 busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_sweep,
        st_ack,
        st_wait_rel
    } state_t;

    state_t               state;
    host_pkg::host_word_u word_q;
    logic                 exec_q; // First cycle after the word is taken
    logic                 is_sweep;

    // Only clear and fill start a sweep
    assign is_sweep = !word_q.cmd.kind &&
                      (word_q.cmd.op == host_pkg::OP_CLEAR ||
                       word_q.cmd.op == host_pkg::OP_FILL);

    assign wr_en       = exec_q && word_q.chr.kind;
    assign wr_addr     = {word_q.chr.row, word_q.chr.col};
    assign wr_char     = word_q.chr.ch;
    assign sweep_start = exec_q && is_sweep;
    assign sweep_char  = (word_q.cmd.op == host_pkg::OP_CLEAR) ? lcd_pkg::lcd_blank
                                                               : word_q.cmd.arg;

    always_ff @(posedge clk) begin
        if (host_req && state == st_idle && !busy)
            word_q <= host_word;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= st_idle;
            exec_q   <= 1'b0;
            host_ack <= 1'b0;
        end else begin
            exec_q <= 1'b0;
            case (state)
                st_idle: begin
                    if (host_req && !busy) begin // Buffer may still be sweeping after reset
                        exec_q <= 1'b1;
                        state  <= st_ack;
                    end
                end
                st_ack: begin
                    if (sweep_start) begin
                        state <= st_wait_sweep;
                    end else begin
                        host_ack <= 1'b1;
                        state    <= st_wait_rel;
                    end
                end
                st_wait_sweep: begin
                    if (!busy)
                        state <= st_ack;
                end
                st_wait_rel: begin
                    if (!host_req) begin
                        host_ack <= 1'b0;
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* verilog/text_buffer.sv */
`timescale 1ns/1ps

module text_buffer (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr_en,
    input  logic [4:0]         wr_addr,
    input  lcd_pkg::lcd_byte_t wr_char,
    input  logic               sweep_start,
    input  lcd_pkg::lcd_byte_t sweep_char,
    output logic               busy,
    input  logic [4:0]         rd_addr,
    output lcd_pkg::lcd_byte_t rd_char
);

    // Row 0 in cells 0..15, row 1 in cells 16..31
    lcd_pkg::lcd_byte_t mem [lcd_pkg::lcd_cells];

    logic [4:0]         sweep_cnt;
    lcd_pkg::lcd_byte_t sweep_val;

    // Sweep engine, reset starts a blank sweep
    always_ff @(posedge clk) begin
        if (!rst) begin
            busy      <= 1'b1;
            sweep_cnt <= '0;
            sweep_val <= lcd_pkg::lcd_blank;
        end else if (busy) begin
            sweep_cnt <= sweep_cnt + 5'd1;
            if (sweep_cnt == 5'(lcd_pkg::lcd_cells - 1))
                busy <= 1'b0;
        end else if (sweep_start) begin
            busy      <= 1'b1;
            sweep_cnt <= '0;
            sweep_val <= sweep_char;
        end
    end

    // One write per cycle, the sweep has priority
    always_ff @(posedge clk) begin
        if (busy)
            mem[sweep_cnt] <= sweep_val;
        else if (wr_en)
            mem[wr_addr] <= wr_char;
    end

    assign rd_char = mem[rd_addr]; // Asynchronous read for the sequencer

endmodule

/* verilog/lcd_sequencer.sv */
`timescale 1ns/1ps

module lcd_sequencer #(
    parameter int clk_div = 20000
) (
    input  logic               clk,
    input  logic               rst,
    output logic [4:0]         rd_addr,
    input  lcd_pkg::lcd_byte_t rd_char,
    output logic               lcd_en,
    output logic               lcd_rw,
    output logic               lcd_rs,
    output lcd_pkg::lcd_byte_t lcd_data
);

    localparam int wait_cycles = lcd_pkg::power_up_periods * clk_div;
    localparam int pwr_w       = $clog2(wait_cycles);
    localparam int div_w       = $clog2(clk_div);
    localparam int half_period = clk_div / 2;

    // Steps 0..4 are the init commands, 5..38 the refresh loop
    localparam int init_steps = 5;
    localparam int loop_steps = 2 * (lcd_pkg::lcd_row_cols + 1);
    localparam int last_step  = init_steps + loop_steps - 1;

    logic [pwr_w-1:0] pwr_cnt;
    logic             pwr_done;
    logic [div_w-1:0] div_cnt;
    logic             load;
    logic [5:0]       step;
    logic [5:0]       loop_idx;

    logic               next_rs;
    lcd_pkg::lcd_byte_t next_data;

    // Power-up wait
    always_ff @(posedge clk) begin
        if (!rst) begin
            pwr_cnt  <= '0;
            pwr_done <= 1'b0;
        end else if (!pwr_done) begin
            pwr_cnt <= pwr_cnt + 1'b1;
            if (pwr_cnt == pwr_w'(wait_cycles - 1))
                pwr_done <= 1'b1;
        end
    end

    // Update period counter
    always_ff @(posedge clk) begin
        if (!rst) begin
            div_cnt <= '0;
        end else if (pwr_done) begin
            if (div_cnt == div_w'(clk_div - 1))
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + 1'b1;
        end
    end

    // First item is loaded in the last cycle of the wait
    assign load = pwr_done ? (div_cnt == div_w'(clk_div - 1))
                           : (pwr_cnt == pwr_w'(wait_cycles - 1));

    assign lcd_en = pwr_done && (div_cnt < div_w'(half_period));
    assign lcd_rw = 1'b0; // Write only

    // Item for the current step
    always_comb begin
        loop_idx  = step - 6'(init_steps);
        next_rs   = 1'b0;
        next_data = lcd_pkg::lcd_cmd_function_set;
        rd_addr   = '0;
        if (step < 6'(init_steps)) begin
            case (step[2:0])
                3'd0:    next_data = lcd_pkg::lcd_cmd_function_set;
                3'd1:    next_data = lcd_pkg::lcd_cmd_display_off;
                3'd2:    next_data = lcd_pkg::lcd_cmd_clear;
                3'd3:    next_data = lcd_pkg::lcd_cmd_entry_mode;
                default: next_data = lcd_pkg::lcd_cmd_display_on;
            endcase
        end else if (loop_idx == 6'd0) begin
            next_data = lcd_pkg::lcd_cmd_row0_addr;
        end else if (loop_idx <= 6'(lcd_pkg::lcd_row_cols)) begin
            // Row 0 characters, cells 0..15
            next_rs   = 1'b1;
            rd_addr   = 5'(loop_idx - 6'd1);
            next_data = rd_char;
        end else if (loop_idx == 6'(lcd_pkg::lcd_row_cols + 1)) begin
            next_data = lcd_pkg::lcd_cmd_row1_addr;
        end else begin
            // Row 1 characters, cells 16..31
            next_rs   = 1'b1;
            rd_addr   = 5'(loop_idx - 6'd2);
            next_data = rd_char;
        end
    end

    // Step counter and pin registers
    always_ff @(posedge clk) begin
        if (!rst) begin
            step     <= '0;
            lcd_rs   <= 1'b0;
            lcd_data <= 8'h00;
        end else if (load) begin
            lcd_rs   <= next_rs;
            lcd_data <= next_data;
            if (step == 6'(last_step))
                step <= 6'(init_steps); // Init runs once
            else
                step <= step + 6'd1;
        end
    end

endmodule

/* verilog/lcd_display_top.sv */
`timescale 1ns/1ps

module lcd_display_top #(
    parameter int clk_div = 20000
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 host_req,
    input  host_pkg::host_word_u host_word,
    output logic                 host_ack,
    output logic                 lcd_en,
    output logic                 lcd_rw,
    output logic                 lcd_rs,
    output lcd_pkg::lcd_byte_t   lcd_data
);

    logic               wr_en;
    logic [4:0]         wr_addr;
    lcd_pkg::lcd_byte_t wr_char;
    logic               sweep_start;
    lcd_pkg::lcd_byte_t sweep_char;
    logic               busy;
    logic [4:0]         rd_addr;
    lcd_pkg::lcd_byte_t rd_char;

    host_decode i_decode (
        .clk         (clk),
        .rst         (rst),
        .host_req    (host_req),
        .host_word   (host_word),
        .host_ack    (host_ack),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_char     (wr_char),
        .sweep_start (sweep_start),
        .sweep_char  (sweep_char),
        .busy        (busy)
    );

    text_buffer i_buffer (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_char     (wr_char),
        .sweep_start (sweep_start),
        .sweep_char  (sweep_char),
        .busy        (busy),
        .rd_addr     (rd_addr),
        .rd_char     (rd_char)
    );

    // Panel refresh runs independently of the host side
    lcd_sequencer #(
        .clk_div (clk_div)
    ) i_sequencer (
        .clk      (clk),
        .rst      (rst),
        .rd_addr  (rd_addr),
        .rd_char  (rd_char),
        .lcd_en   (lcd_en),
        .lcd_rw   (lcd_rw),
        .lcd_rs   (lcd_rs),
        .lcd_data (lcd_data)
    );

endmodule

/* verification/lcd_bus_monitor.sv */
`timescale 1ns/1ps

module lcd_bus_monitor (
    input  logic               clk,
    input  logic               rst,
    input  logic               lcd_en,
    input  logic               lcd_rs,
    input  lcd_pkg::lcd_byte_t lcd_data,
    output logic               seen,     // One-cycle pulse per bus write
    output logic               seen_rs,
    output lcd_pkg::lcd_byte_t seen_data
);

    logic en_q;
    logic en_fall;

    // The panel latches rs and data on the falling edge of enable
    assign en_fall = en_q && !lcd_en;

    always_ff @(posedge clk) begin
        if (!rst) begin
            en_q      <= 1'b0;
            seen      <= 1'b0;
            seen_rs   <= 1'b0;
            seen_data <= 8'h00;
        end else begin
            en_q <= lcd_en;
            seen <= en_fall;
            if (en_fall) begin
                seen_rs   <= lcd_rs;
                seen_data <= lcd_data;
            end
        end
    end

endmodule

/* verification/tb_lcd_display.sv */
`timescale 1ns/1ps

module tb_lcd_display;

    localparam int clk_div     = 8;
    localparam int ack_limit   = 100;
    localparam int write_limit = (lcd_pkg::power_up_periods + 2) * clk_div;

    logic                 clk;
    logic                 rst;
    logic                 host_req;
    host_pkg::host_word_u host_word;
    logic                 host_ack;
    logic                 lcd_en;
    logic                 lcd_rw;
    logic                 lcd_rs;
    lcd_pkg::lcd_byte_t   lcd_data;
    logic                 seen;
    logic                 seen_rs;
    lcd_pkg::lcd_byte_t   seen_data;

    logic [8:0]         bus_q[$]; // {rs, data} per bus write
    lcd_pkg::lcd_byte_t model [lcd_pkg::lcd_cells];
    logic [31:0]        lfsr = 32'h73c2_f31e;
    int                 errors = 0;
    int                 tests = 0;
    logic               aborted = 1'b0;
    logic               req_q = 1'b0;
    logic               ack_q = 1'b0;

    lcd_display_top #(
        .clk_div (clk_div)
    ) i_dut (
        .clk       (clk),
        .rst       (rst),
        .host_req  (host_req),
        .host_word (host_word),
        .host_ack  (host_ack),
        .lcd_en    (lcd_en),
        .lcd_rw    (lcd_rw),
        .lcd_rs    (lcd_rs),
        .lcd_data  (lcd_data)
    );

    lcd_bus_monitor i_mon (
        .clk       (clk),
        .rst       (rst),
        .lcd_en    (lcd_en),
        .lcd_rs    (lcd_rs),
        .lcd_data  (lcd_data),
        .seen      (seen),
        .seen_rs   (seen_rs),
        .seen_data (seen_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (seen)
            bus_q.push_back({seen_rs, seen_data});
    end

    // Four-phase rules, judged on levels sampled at rising edges
    always @(posedge clk) begin
        if (rst) begin
            if (host_ack && !ack_q && !req_q) begin
                $display("[%0t] host_ack rose while host_req was low", $time);
                errors++;
            end
            if (!host_ack && ack_q && req_q) begin
                $display("[%0t] host_ack fell while host_req was still high", $time);
                errors++;
            end
            if (host_req && !req_q && host_ack) begin
                $display("[%0t] host_req rose while host_ack was high", $time);
                errors++;
            end
        end
        req_q <= host_req;
        ack_q <= host_ack;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic next_write(output logic rs, output lcd_pkg::lcd_byte_t data);
        int         n;
        logic [8:0] entry;
        rs   = 1'b0;
        data = 8'h00;
        n    = 0;
        while (!aborted && bus_q.size() == 0 && n < write_limit) begin
            @(negedge clk);
            n++;
        end
        if (!aborted && bus_q.size() == 0) begin
            $display("[%0t] no LCD bus write within %0d cycles", $time, write_limit);
            aborted = 1'b1;
            errors++;
        end else if (!aborted) begin
            entry = bus_q.pop_front();
            rs    = entry[8];
            data  = entry[7:0];
        end
    endtask

    task automatic check_command(input lcd_pkg::lcd_byte_t exp, input string what);
        logic               rs;
        lcd_pkg::lcd_byte_t got;
        next_write(rs, got);
        if (!aborted && (rs !== 1'b0 || got !== exp)) begin
            $display("MISMATCH at %0t: %s expected command %02h, got %02h rs %0b",
                     $time, what, exp, got, rs);
            errors++;
        end
    endtask

    task automatic check_char(input lcd_pkg::lcd_byte_t exp, input string what);
        logic               rs;
        lcd_pkg::lcd_byte_t got;
        next_write(rs, got);
        if (!aborted && (rs !== 1'b1 || got !== exp)) begin
            $display("MISMATCH at %0t: %s expected char %02h, got %02h rs %0b",
                     $time, what, exp, got, rs);
            errors++;
        end
    endtask

    task automatic check_ack(input logic exp, input string what);
        if (host_ack !== exp) begin
            $display("MISMATCH at %0t: %s expected host_ack %0b, got %0b",
                     $time, what, exp, host_ack);
            errors++;
        end
    endtask

    task automatic check_pins();
        if (lcd_en !== 1'b0 || lcd_rs !== 1'b0 || lcd_rw !== 1'b0 || lcd_data !== 8'h00) begin
            $display("MISMATCH at %0t: idle pins not low, en %0b rs %0b rw %0b data %02h",
                     $time, lcd_en, lcd_rs, lcd_rw, lcd_data);
            errors++;
        end
    endtask

    task automatic send_word(input host_pkg::host_word_u w);
        int n;
        if (!aborted) begin
            check_ack(1'b0, "before req");
            host_word = w;
            host_req  = 1'b1;
            n = 0;
            while (!host_ack && n < ack_limit) begin
                @(negedge clk);
                n++;
            end
            if (!host_ack) begin
                $display("[%0t] host_ack did not rise within %0d cycles", $time, ack_limit);
                aborted = 1'b1;
                errors++;
            end else begin
                host_req = 1'b0;
                n = 0;
                while (host_ack && n < ack_limit) begin
                    @(negedge clk);
                    n++;
                end
                if (host_ack) begin
                    $display("[%0t] host_ack did not fall within %0d cycles", $time, ack_limit);
                    aborted = 1'b1;
                    errors++;
                end
            end
        end
    endtask

    task automatic write_random_char();
        host_pkg::host_word_u w;
        logic [31:0]          bits;
        bits       = rand_bits(13);
        w          = '0;
        w.chr.kind = 1'b1;
        w.chr.row  = bits[12];
        w.chr.col  = bits[11:8];
        w.chr.ch   = bits[7:0];
        send_word(w);
        if (!aborted)
            model[{w.chr.row, w.chr.col}] = w.chr.ch;
    endtask

    task automatic send_command(input host_pkg::host_op_e op, input lcd_pkg::lcd_byte_t arg);
        host_pkg::host_word_u w;
        int                   i;
        w         = '0;
        w.cmd.op  = op;
        w.cmd.arg = arg;
        send_word(w);
        for (i = 0; i < lcd_pkg::lcd_cells; i++) begin
            if (!aborted && op == host_pkg::OP_CLEAR)
                model[i] = lcd_pkg::lcd_blank;
            else if (!aborted && op == host_pkg::OP_FILL)
                model[i] = arg;
        end
    endtask

    // Drop stale writes, then skip to the next row 0 address
    task automatic sync_frame();
        logic               rs;
        lcd_pkg::lcd_byte_t got;
        int                 n;
        bus_q.delete();
        rs  = 1'b1;
        got = 8'h00;
        n   = 0;
        while (!aborted && n < 40 && !(rs == 1'b0 && got == lcd_pkg::lcd_cmd_row0_addr)) begin
            next_write(rs, got);
            n++;
        end
        if (!aborted && !(rs == 1'b0 && got == lcd_pkg::lcd_cmd_row0_addr)) begin
            $display("[%0t] no row 0 address among %0d bus writes", $time, n);
            aborted = 1'b1;
            errors++;
        end
    endtask

    task automatic check_frame_body(input string what);
        int i;
        for (i = 0; i < lcd_pkg::lcd_row_cols; i++)
            check_char(model[i], $sformatf("%s cell %0d", what, i));
        check_command(lcd_pkg::lcd_cmd_row1_addr, {what, " row 1 address"});
        for (i = lcd_pkg::lcd_row_cols; i < lcd_pkg::lcd_cells; i++)
            check_char(model[i], $sformatf("%s cell %0d", what, i));
    endtask

    task automatic report_test(input string name, input int n);
        tests++;
        if (n == 0)
            $display("[%0t] %-18s ok", $time, name);
        else
            $display("[%0t] %-18s FAIL, %0d errors", $time, name, n);
    endtask

    initial begin
        int          base;
        int          i;
        logic [31:0] bits;
        logic [2:0]  op_bits;
        host_req  = 1'b0;
        host_word = '0;
        rst       = 1'b0;
        for (i = 0; i < lcd_pkg::lcd_cells; i++)
            model[i] = lcd_pkg::lcd_blank;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        base = errors;
        check_pins();
        check_ack(1'b0, "after reset");
        check_command(lcd_pkg::lcd_cmd_function_set, "init function set");
        check_command(lcd_pkg::lcd_cmd_display_off, "init display off");
        check_command(lcd_pkg::lcd_cmd_clear, "init clear");
        check_command(lcd_pkg::lcd_cmd_entry_mode, "init entry mode");
        check_command(lcd_pkg::lcd_cmd_display_on, "init display on");
        check_command(lcd_pkg::lcd_cmd_row0_addr, "first frame row 0 address");
        check_frame_body("first frame");
        report_test("reset and init", errors - base);

        base = errors;
        for (i = 0; i < 12; i++)
            write_random_char();
        sync_frame();
        check_frame_body("after writes");
        check_command(lcd_pkg::lcd_cmd_row0_addr, "next frame row 0 address");
        check_frame_body("next frame");
        report_test("character writes", errors - base);

        base = errors;
        bits = rand_bits(8);
        send_command(host_pkg::OP_CLEAR, bits[7:0]); // Arg is ignored by clear
        sync_frame();
        check_frame_body("after clear");
        report_test("clear", errors - base);

        base = errors;
        bits = rand_bits(8);
        send_command(host_pkg::OP_FILL, bits[7:0]);
        sync_frame();
        check_frame_body("after fill");
        for (i = 0; i < 6; i++)
            write_random_char();
        sync_frame();
        check_frame_body("writes over fill");
        report_test("fill", errors - base);

        // Unknown opcodes must be acknowledged without touching the screen
        base = errors;
        for (i = 0; i < 5; i++) begin
            bits    = rand_bits(11);
            op_bits = bits[10:8];
            if (op_bits < 3'd2)
                op_bits = op_bits + 3'd2;
            send_command(host_pkg::host_op_e'(op_bits), bits[7:0]);
        end
        sync_frame();
        check_frame_body("after unknown ops");
        report_test("handshake", errors - base);

        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

/* list.f */
verilog/host_pkg.sv
verilog/lcd_pkg.sv
verilog/host_decode.sv
verilog/text_buffer.sv
verilog/lcd_sequencer.sv
verilog/lcd_display_top.sv
verification/lcd_bus_monitor.sv
verification/tb_lcd_display.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the LCD display testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_lcd_display -f list.f -o sim_lcd_display
./obj_dir/sim_lcd_display > sim.log
cat sim.log

if grep -q "^test passed$" sim.log; then
    echo "Simulation PASS"
else
    echo "Simulation FAIL"
    exit 1
fi
